//--- hw/boot_cfg_consts.svh
`ifndef BOOT_CFG_CONSTS_SVH
`define BOOT_CFG_CONSTS_SVH

// link widths.
`define CFG_ADDR_W 16
`define CFG_DATA_W 16

// microcode store, one instruction is two link halves.
`define INST_W 32
`define UCODE_ELS 16
`define UCODE_ADDR_W 4

// control register map.
`define REG_RESET 16'h0001
`define REG_FREEZE 16'h0002
`define REG_MODE 16'h0003
`define REG_PC_LO 16'h0004
`define REG_PC_HI 16'h0005

// word i sits at base + 2*i (low half) and base + 2*i + 1 (high half).
`define UCODE_BASE 16'h8000

// first instruction fetched after boot.
`define PC_ENTRY 32'd3

`endif

//--- hw/boot_cfg_pkg.sv
`include "boot_cfg_consts.svh"

package boot_cfg_pkg;

  typedef logic [`CFG_ADDR_W-1:0] cfg_addr_t;
  typedef logic [`CFG_DATA_W-1:0] cfg_data_t;
  typedef logic [`INST_W-1:0] inst_t;
  typedef logic [`UCODE_ADDR_W-1:0] ucode_idx_t;
  typedef logic [31:0] pc_t;

  typedef enum logic {
    MODE_UNCACHED = 1'b0,
    MODE_NORMAL = 1'b1
  } engine_mode_e;

  typedef enum logic [3:0] {
    ST_START,
    ST_RESET_SET,
    ST_FREEZE_SET,
    ST_RESET_CLR,
    ST_SEND_RAM, // both halves of every microcode word.
    ST_SEND_MODE,
    ST_SEND_PC_LO,
    ST_SEND_PC_HI,
    ST_FREEZE_CLR,
    ST_DONE
  } loader_state_e;

  typedef struct packed {
    cfg_addr_t addr;
    cfg_data_t data;
  } cfg_wr_s;

  typedef struct packed {
    logic en;
    ucode_idx_t idx;
    logic hi; // upper half of the word.
    cfg_data_t data;
  } ucode_wr_s;

endpackage

//--- hw/boot_cfg_top.sv
`timescale 1ns/1ps

module boot_cfg_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  output boot_cfg_pkg::ucode_idx_t boot_rom_addr_o,
  input  boot_cfg_pkg::inst_t      boot_rom_data_i,
  input  logic                     link_stall_i,
  output logic                     boot_done_o,
  output logic                     inst_v_o,
  output boot_cfg_pkg::ucode_idx_t inst_addr_o,
  output boot_cfg_pkg::inst_t      inst_o
);

  boot_cfg_pkg::cfg_wr_s cfg_wr;
  logic cfg_v;
  logic cfg_yumi;
  boot_cfg_pkg::ucode_wr_s ucode_wr;
  logic core_reset;
  logic freeze;
  boot_cfg_pkg::engine_mode_e mode;
  boot_cfg_pkg::pc_t start_pc;
  boot_cfg_pkg::ucode_idx_t rd_idx;
  boot_cfg_pkg::inst_t rd_data;

  cfg_loader loader0 (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .boot_rom_addr_o(boot_rom_addr_o),
    .boot_rom_data_i(boot_rom_data_i),
    .cfg_wr_o(cfg_wr),
    .cfg_v_o(cfg_v),
    .cfg_yumi_i(cfg_yumi),
    .boot_done_o(boot_done_o)
  );

  cfg_reg_block regs0 (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .cfg_wr_i(cfg_wr),
    .cfg_v_i(cfg_v),
    .cfg_yumi_o(cfg_yumi),
    .link_stall_i(link_stall_i),
    .ucode_wr_o(ucode_wr),
    .core_reset_o(core_reset),
    .freeze_o(freeze),
    .mode_o(mode),
    .start_pc_o(start_pc)
  );

  ucode_ram ram0 (
    .clk_i(clk_i),
    .ucode_wr_i(ucode_wr),
    .rd_idx_i(rd_idx),
    .rd_data_o(rd_data)
  );

  ucode_fetch fetch0 (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .core_reset_i(core_reset),
    .freeze_i(freeze),
    .mode_i(mode),
    .start_pc_i(start_pc),
    .rd_idx_o(rd_idx),
    .rd_data_i(rd_data),
    .inst_v_o(inst_v_o),
    .inst_addr_o(inst_addr_o),
    .inst_o(inst_o)
  );

endmodule

//--- hw/cfg_loader.sv
`timescale 1ns/1ps
`include "boot_cfg_consts.svh"

module cfg_loader (
  input  logic                   clk_i,
  input  logic                   reset_i,
  output boot_cfg_pkg::ucode_idx_t boot_rom_addr_o,
  input  boot_cfg_pkg::inst_t      boot_rom_data_i,
  output boot_cfg_pkg::cfg_wr_s    cfg_wr_o,
  output logic                   cfg_v_o,
  input  logic                   cfg_yumi_i,
  output logic                   boot_done_o
);

  localparam boot_cfg_pkg::pc_t pc_entry = `PC_ENTRY;

  boot_cfg_pkg::loader_state_e state_r, state_n;
  boot_cfg_pkg::ucode_idx_t word_cnt_r;
  logic half_r;
  logic accept;
  logic advance;
  logic last_half;

  assign accept = cfg_v_o & cfg_yumi_i;
  assign advance = (state_r == boot_cfg_pkg::ST_START) | accept; // start never waits.
  assign last_half = half_r & (word_cnt_r == boot_cfg_pkg::ucode_idx_t'(`UCODE_ELS - 1));

  assign boot_rom_addr_o = word_cnt_r;
  assign boot_done_o = (state_r == boot_cfg_pkg::ST_DONE);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= boot_cfg_pkg::ST_START;
      word_cnt_r <= '0;
      half_r <= 1'b0;
    end else begin
      if (advance) begin
        state_r <= state_n;
      end
      if (accept && state_r == boot_cfg_pkg::ST_SEND_RAM) begin
        half_r <= ~half_r;
        if (half_r) begin
          word_cnt_r <= word_cnt_r + 1'b1; // wraps to 0 after the last word.
        end
      end
    end
  end

  always_comb begin
    state_n = state_r;
    cfg_v_o = 1'b0;
    cfg_wr_o.addr = '0;
    cfg_wr_o.data = '0;

    case (state_r)
      boot_cfg_pkg::ST_START: begin
        state_n = boot_cfg_pkg::ST_RESET_SET;
      end
      boot_cfg_pkg::ST_RESET_SET: begin
        state_n = boot_cfg_pkg::ST_FREEZE_SET;
        cfg_v_o = 1'b1;
        cfg_wr_o.addr = `REG_RESET;
        cfg_wr_o.data = boot_cfg_pkg::cfg_data_t'(1'b1);
      end
      boot_cfg_pkg::ST_FREEZE_SET: begin
        state_n = boot_cfg_pkg::ST_RESET_CLR;
        cfg_v_o = 1'b1;
        cfg_wr_o.addr = `REG_FREEZE;
        cfg_wr_o.data = boot_cfg_pkg::cfg_data_t'(1'b1);
      end
      boot_cfg_pkg::ST_RESET_CLR: begin
        state_n = boot_cfg_pkg::ST_SEND_RAM;
        cfg_v_o = 1'b1;
        cfg_wr_o.addr = `REG_RESET;
        cfg_wr_o.data = boot_cfg_pkg::cfg_data_t'(1'b0);
      end
      boot_cfg_pkg::ST_SEND_RAM: begin
        state_n = last_half ? boot_cfg_pkg::ST_SEND_MODE : boot_cfg_pkg::ST_SEND_RAM;
        cfg_v_o = 1'b1;
        cfg_wr_o.addr = `UCODE_BASE + boot_cfg_pkg::cfg_addr_t'({word_cnt_r, half_r});
        cfg_wr_o.data = half_r ? boot_rom_data_i[`CFG_DATA_W+:`CFG_DATA_W]
                               : boot_rom_data_i[0+:`CFG_DATA_W];
      end
      boot_cfg_pkg::ST_SEND_MODE: begin
        state_n = boot_cfg_pkg::ST_SEND_PC_LO;
        cfg_v_o = 1'b1;
        cfg_wr_o.addr = `REG_MODE;
        cfg_wr_o.data = boot_cfg_pkg::cfg_data_t'(boot_cfg_pkg::MODE_NORMAL);
      end
      boot_cfg_pkg::ST_SEND_PC_LO: begin
        state_n = boot_cfg_pkg::ST_SEND_PC_HI;
        cfg_v_o = 1'b1;
        cfg_wr_o.addr = `REG_PC_LO;
        cfg_wr_o.data = pc_entry[0+:`CFG_DATA_W];
      end
      boot_cfg_pkg::ST_SEND_PC_HI: begin
        state_n = boot_cfg_pkg::ST_FREEZE_CLR;
        cfg_v_o = 1'b1;
        cfg_wr_o.addr = `REG_PC_HI;
        cfg_wr_o.data = pc_entry[`CFG_DATA_W+:`CFG_DATA_W];
      end
      boot_cfg_pkg::ST_FREEZE_CLR: begin
        state_n = boot_cfg_pkg::ST_DONE;
        cfg_v_o = 1'b1;
        cfg_wr_o.addr = `REG_FREEZE;
        cfg_wr_o.data = boot_cfg_pkg::cfg_data_t'(1'b0);
      end
      boot_cfg_pkg::ST_DONE: begin
        state_n = boot_cfg_pkg::ST_DONE; // parks here until the next reset.
      end
      default: begin
        state_n = boot_cfg_pkg::ST_START;
      end
    endcase
  end

endmodule

//--- hw/cfg_reg_block.sv
`timescale 1ns/1ps
`include "boot_cfg_consts.svh"

module cfg_reg_block (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  boot_cfg_pkg::cfg_wr_s      cfg_wr_i,
  input  logic                       cfg_v_i,
  output logic                       cfg_yumi_o,
  input  logic                       link_stall_i,
  output boot_cfg_pkg::ucode_wr_s    ucode_wr_o,
  output logic                       core_reset_o,
  output logic                       freeze_o,
  output boot_cfg_pkg::engine_mode_e mode_o,
  output boot_cfg_pkg::pc_t          start_pc_o
);

  boot_cfg_pkg::cfg_addr_t ucode_ofs;
  logic accept;
  logic in_ucode;

  assign cfg_yumi_o = cfg_v_i & ~link_stall_i;
  assign accept = cfg_v_i & cfg_yumi_o;

  // offset into the microcode window, lsb picks the half.
  assign ucode_ofs = cfg_wr_i.addr - `UCODE_BASE;
  assign in_ucode = (cfg_wr_i.addr >= `UCODE_BASE)
                  & (ucode_ofs < boot_cfg_pkg::cfg_addr_t'(2 * `UCODE_ELS));

  assign ucode_wr_o.en = accept & in_ucode;
  assign ucode_wr_o.idx = ucode_ofs[`UCODE_ADDR_W:1];
  assign ucode_wr_o.hi = ucode_ofs[0];
  assign ucode_wr_o.data = cfg_wr_i.data;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      core_reset_o <= 1'b1; // engine held until the loader releases it.
      freeze_o <= 1'b1;
      mode_o <= boot_cfg_pkg::MODE_UNCACHED;
      start_pc_o <= '0;
    end else if (accept) begin
      case (cfg_wr_i.addr)
        `REG_RESET: begin
          core_reset_o <= cfg_wr_i.data[0];
        end
        `REG_FREEZE: begin
          freeze_o <= cfg_wr_i.data[0];
        end
        `REG_MODE: begin
          mode_o <= boot_cfg_pkg::engine_mode_e'(cfg_wr_i.data[0]);
        end
        `REG_PC_LO: begin
          start_pc_o[0+:`CFG_DATA_W] <= cfg_wr_i.data;
        end
        `REG_PC_HI: begin
          start_pc_o[`CFG_DATA_W+:`CFG_DATA_W] <= cfg_wr_i.data;
        end
        default: begin
          // microcode window or unmapped, nothing to latch here.
        end
      endcase
    end
  end

endmodule

//--- hw/ucode_fetch.sv
`timescale 1ns/1ps
`include "boot_cfg_consts.svh"

module ucode_fetch (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       core_reset_i,
  input  logic                       freeze_i,
  input  boot_cfg_pkg::engine_mode_e mode_i,
  input  boot_cfg_pkg::pc_t          start_pc_i,
  output boot_cfg_pkg::ucode_idx_t   rd_idx_o,
  input  boot_cfg_pkg::inst_t        rd_data_i,
  output logic                       inst_v_o,
  output boot_cfg_pkg::ucode_idx_t   inst_addr_o,
  output boot_cfg_pkg::inst_t        inst_o
);

  boot_cfg_pkg::ucode_idx_t pc_r;
  logic run;
  logic run_r;

  assign run = ~core_reset_i & ~freeze_i & (mode_i == boot_cfg_pkg::MODE_NORMAL);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      run_r <= 1'b0;
      pc_r <= '0;
    end else begin
      run_r <= run;
      if (run && !run_r) begin
        pc_r <= start_pc_i[`UCODE_ADDR_W-1:0]; // entry point on run start.
      end else if (run_r) begin
        pc_r <= pc_r + 1'b1; // wraps at the end of the store.
      end
    end
  end

  assign rd_idx_o = pc_r;
  assign inst_v_o = run_r;
  assign inst_addr_o = pc_r;
  assign inst_o = rd_data_i;

endmodule

//--- hw/ucode_ram.sv
`timescale 1ns/1ps
`include "boot_cfg_consts.svh"

module ucode_ram (
  input  logic                    clk_i,
  input  boot_cfg_pkg::ucode_wr_s ucode_wr_i,
  input  boot_cfg_pkg::ucode_idx_t rd_idx_i,
  output boot_cfg_pkg::inst_t     rd_data_o
);

  // separate lanes so each half can be written on its own.
  boot_cfg_pkg::cfg_data_t mem_lo [`UCODE_ELS];
  boot_cfg_pkg::cfg_data_t mem_hi [`UCODE_ELS];

  always_ff @(posedge clk_i) begin
    if (ucode_wr_i.en) begin
      if (ucode_wr_i.hi) begin
        mem_hi[ucode_wr_i.idx] <= ucode_wr_i.data;
      end else begin
        mem_lo[ucode_wr_i.idx] <= ucode_wr_i.data;
      end
    end
  end

  assign rd_data_o = {mem_hi[rd_idx_i], mem_lo[rd_idx_i]}; // async read.

endmodule

//--- tb.f
+incdir+hw
hw/boot_cfg_pkg.sv
hw/cfg_loader.sv
hw/cfg_reg_block.sv
hw/ucode_ram.sv
hw/ucode_fetch.sv
hw/boot_cfg_top.sv
testbench/boot_cfg_assertions.sv
testbench/tb_boot_cfg.sv

//--- testbench/boot_cfg_assertions.sv
`timescale 1ns/1ps

module boot_cfg_assertions (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  cfg_v_i,
  input logic                  cfg_yumi_i,
  input boot_cfg_pkg::cfg_wr_s cfg_wr_i,
  input logic                  freeze_i,
  input logic                  inst_v_i
);

  int fail_cnt = 0; // read by the testbench at the end of the run.

  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    cfg_yumi_i |-> cfg_v_i)
    else begin
      $error("cfg_yumi high without cfg_v");
      fail_cnt++;
    end

  // a stalled write must not change until it is taken.
  wr_stable_while_stalled: assert property (@(posedge clk_i) disable iff (reset_i)
    cfg_v_i && !cfg_yumi_i |=> cfg_v_i && $stable(cfg_wr_i))
    else begin
      $error("cfg_wr changed or dropped while not accepted");
      fail_cnt++;
    end

  no_fetch_when_frozen: assert property (@(posedge clk_i) disable iff (reset_i)
    freeze_i |-> !inst_v_i)
    else begin
      $error("inst_v_o high while freeze is set");
      fail_cnt++;
    end

endmodule

bind cfg_reg_block boot_cfg_assertions link_chk (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .cfg_v_i(cfg_v_i),
  .cfg_yumi_i(cfg_yumi_o),
  .cfg_wr_i(cfg_wr_i),
  .freeze_i(1'b0),
  .inst_v_i(1'b0)
);

bind ucode_fetch boot_cfg_assertions fetch_chk (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .cfg_v_i(1'b0),
  .cfg_yumi_i(1'b0),
  .cfg_wr_i('0),
  .freeze_i(freeze_i),
  .inst_v_i(inst_v_o)
);

//--- testbench/boot_cfg_vectors.txt
// lines 1 to 16: boot ROM words 0 to 15, one 32-bit hex word each.
// line 17: expected entry index. line 18: instructions to check per run.
1a2b3c4d
5e6f7081
92a3b4c5
d6e7f809
0badcafe
13579bdf
2468ace0
fedcba98
76543210
c001d00d
a5a55a5a
3c3cc3c3
0f1e2d3c
4b5a6978
87960000
ffff1234
00000003
00000028

//--- testbench/tb_boot_cfg.sv
`timescale 1ns/1ps
`include "boot_cfg_consts.svh"

module tb_boot_cfg;

  localparam int RESET_CYCLES = 16;
  localparam int BOOT_WRITES = 39;
  localparam int RUNS = 3;
  localparam int GATE_MAX = 8; // cycles from boot done to first valid instruction.
  localparam int VEC_ENTRY = `UCODE_ELS;
  localparam int VEC_CHECKS = `UCODE_ELS + 1;

  logic clk_i;
  logic reset_i;
  logic link_stall_i;
  boot_cfg_pkg::ucode_idx_t boot_rom_addr;
  boot_cfg_pkg::inst_t boot_rom_data;
  logic boot_done;
  logic inst_v;
  boot_cfg_pkg::ucode_idx_t inst_addr;
  boot_cfg_pkg::inst_t inst;

  logic [31:0] vec_mem [0:`UCODE_ELS+1];
  boot_cfg_pkg::inst_t rom_mem [`UCODE_ELS];
  boot_cfg_pkg::ucode_idx_t entry_idx;
  int check_cnt;
  int cycle_cnt;
  int cycle_limit;
  logic stall_en;
  logic [15:0] lfsr_r;

  boot_cfg_top dut0 (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .boot_rom_addr_o(boot_rom_addr),
    .boot_rom_data_i(boot_rom_data),
    .link_stall_i(link_stall_i),
    .boot_done_o(boot_done),
    .inst_v_o(inst_v),
    .inst_addr_o(inst_addr),
    .inst_o(inst)
  );

  assign boot_rom_data = rom_mem[boot_rom_addr]; // asynchronous boot ROM.

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  always @(posedge clk_i) begin
    if (stall_en) begin
      lfsr_r = lfsr_step(lfsr_r);
      link_stall_i <= lfsr_r[0]; // one step per stall bit.
    end else begin
      link_stall_i <= 1'b0;
    end
  end

  task automatic fail_stop(input string why);
    $display("TEST FAILED");
    $fatal(1, "%s", why);
  endtask

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout, runs not finished after %0d cycles", cycle_cnt);
      fail_stop("timeout");
    end
  end

  task automatic check_inst(input boot_cfg_pkg::inst_t got, input boot_cfg_pkg::inst_t exp,
                            input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      fail_stop("instruction mismatch");
    end
  endtask

  task automatic check_idx(input boot_cfg_pkg::ucode_idx_t got,
                           input boot_cfg_pkg::ucode_idx_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
      fail_stop("index mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      fail_stop("flag mismatch");
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    reset_i <= 1'b1;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk_i);
      if (i == RESET_CYCLES - 1) begin
        reset_i <= 1'b0;
      end
      @(negedge clk_i);
      check_flag(boot_done, 1'b0, "boot done during reset");
      check_flag(inst_v, 1'b0, "inst valid during reset");
    end
  endtask

  // follows the rom address until the loader reports done.
  task automatic watch_boot();
    boot_cfg_pkg::ucode_idx_t walk_prev;
    boot_cfg_pkg::ucode_idx_t walk_exp;
    logic [`UCODE_ELS-1:0] walk_seen;
    walk_prev = '0;
    walk_seen = '0;
    walk_seen[0] = 1'b1;
    check_idx(boot_rom_addr, '0, "rom address after reset");
    while (boot_done !== 1'b1) begin
      @(posedge clk_i);
      @(negedge clk_i);
      if (boot_done !== 1'b1) begin
        check_flag(inst_v, 1'b0, "inst valid before boot done");
      end
      if (boot_rom_addr !== walk_prev) begin
        walk_exp = walk_prev + 1'b1;
        check_idx(boot_rom_addr, walk_exp, "rom walk order");
        walk_prev = boot_rom_addr;
        walk_seen[walk_prev] = 1'b1;
      end
    end
    if (walk_seen !== '1) begin
      $display("boot finished after visiting only %0d rom words", $countones(walk_seen));
      fail_stop("incomplete rom walk");
    end
  endtask

  task automatic check_stream();
    boot_cfg_pkg::ucode_idx_t exp_idx;
    int wait_cnt;
    wait_cnt = 0;
    while (inst_v !== 1'b1) begin
      if (wait_cnt == GATE_MAX) begin
        $display("inst valid did not rise within %0d cycles of boot done", GATE_MAX);
        fail_stop("fetch never started");
      end
      @(posedge clk_i);
      @(negedge clk_i);
      wait_cnt++;
    end
    exp_idx = entry_idx;
    for (int k = 0; k < check_cnt; k++) begin
      check_flag(inst_v, 1'b1, "inst valid during stream");
      check_idx(inst_addr, exp_idx, "fetch address");
      check_inst(inst, rom_mem[exp_idx], "fetched instruction");
      exp_idx = exp_idx + 1'b1; // wraps with the store.
      @(posedge clk_i);
      @(negedge clk_i);
    end
  endtask

  task automatic do_run(input logic use_stall, input int run_idx);
    if (run_idx > 1) begin
      check_flag(boot_done, 1'b1, "boot done before re-reset");
      check_flag(inst_v, 1'b1, "stream running before re-reset");
    end
    @(posedge clk_i);
    stall_en <= use_stall;
    apply_reset();
    watch_boot();
    check_stream();
  endtask

  initial begin
    int asrt_fails;
    reset_i = 1'b1;
    link_stall_i = 1'b0;
    stall_en = 1'b0;
    lfsr_r = 16'd8;
    cycle_cnt = 0;
    $readmemh("testbench/boot_cfg_vectors.txt", vec_mem);
    if ($isunknown(vec_mem[VEC_CHECKS])) begin
      $display("vectors file missing or too short");
      fail_stop("no vectors");
    end
    for (int i = 0; i < `UCODE_ELS; i++) begin
      rom_mem[i] = vec_mem[i];
    end
    entry_idx = vec_mem[VEC_ENTRY][`UCODE_ADDR_W-1:0];
    check_cnt = vec_mem[VEC_CHECKS];
    cycle_limit = RUNS * (RESET_CYCLES + BOOT_WRITES * 16 + 2 * check_cnt + 100);

    do_run(1'b1, 1); // random stall.
    do_run(1'b0, 2); // no stall, entered by a mid-stream reset.
    do_run(1'b1, 3);

    asrt_fails = dut0.regs0.link_chk.fail_cnt + dut0.fetch0.fetch_chk.fail_cnt;
    if (asrt_fails == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("%0d assertion failures", asrt_fails);
      fail_stop("run ended with failures");
    end
  end

endmodule
